/* axi3_wreorder.f */
+incdir+include
hw/wreorder_pkg.sv
hw/sync_fifo.sv
hw/w_beat_bank.sv
hw/w_burst_emit.sv
hw/axi3_wreorder.sv
test/tb_axi3_wreorder.sv

/* build.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
	--top-module tb_axi3_wreorder \
	-Mdir obj_dir -o tb_axi3_wreorder \
	-f axi3_wreorder.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_axi3_wreorder > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Done: errors found" "$LOG"; then
	echo "Simulation failed"
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "Simulator exited with status $sim_status"
	exit 1
fi
echo "Simulation passed"
exit 0

/* hw/axi3_wreorder.sv */
// Takes only AWID from AW; address fields and the B and R channels belong to other logic
`timescale 1ns/1ps

module axi3_wreorder #(
	// AW ID queue holds 2^LG_AW_DEPTH IDs
	parameter int LG_AW_DEPTH = 3,
	// Each beat FIFO holds 2^LG_W_DEPTH beats
	parameter int LG_W_DEPTH = 4
) (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	// AW ID, slave side
	input logic i_s_awvalid,
	output logic o_s_awready,
	input wreorder_pkg::axi_id_t i_s_awid,
	// W, slave side
	input logic i_s_wvalid,
	output logic o_s_wready,
	input wreorder_pkg::w_beat_t i_s_wbeat,
	// W, master side, in AW order
	output logic o_m_wvalid,
	input logic i_m_wready,
	output wreorder_pkg::w_beat_t o_m_wbeat
);

	import wreorder_pkg::*;

	// AW queue
	logic aw_full;
	logic aw_empty;
	logic aw_pop;
	axi_id_t aw_head;

	// Bank to emitter
	axi_id_t sel_id;
	logic bank_pop;
	w_beat_t bank_head;
	logic bank_empty;

	//////////////////////////////////////////////////////////////////////////////
	// AW ID queue
	//////////////////////////////////////////////////////////////////////////////

	assign o_s_awready = !aw_full;

	sync_fifo #(
		.WIDTH(ID_W),
		.LG_DEPTH(LG_AW_DEPTH)
	) u_aw_queue (
		.i_clk(S_AXI_ACLK),
		.i_reset(!S_AXI_ARESETN),
		.i_wr(i_s_awvalid && o_s_awready),
		.i_data(i_s_awid),
		.o_full(aw_full),
		.i_rd(aw_pop),
		.o_data(aw_head),
		.o_empty(aw_empty)
	);

	// Per-ID beat storage
	w_beat_bank #(
		.LG_W_DEPTH(LG_W_DEPTH)
	) u_bank (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_s_wvalid(i_s_wvalid),
		.o_s_wready(o_s_wready),
		.i_s_wbeat(i_s_wbeat),
		.i_sel_id(sel_id),
		.i_pop(bank_pop),
		.o_head(bank_head),
		.o_head_empty(bank_empty)
	);

	// Burst sequencing and output register
	w_burst_emit u_emit (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_aw_id(aw_head),
		.i_aw_empty(aw_empty),
		.o_aw_pop(aw_pop),
		.o_sel_id(sel_id),
		.o_pop(bank_pop),
		.i_head(bank_head),
		.i_head_empty(bank_empty),
		.o_m_wvalid(o_m_wvalid),
		.i_m_wready(i_m_wready),
		.o_m_wbeat(o_m_wbeat)
	);

endmodule

/* hw/sync_fifo.sv */
// First-word-fall-through FIFO; i_reset is active high; overflow and underflow are ignored
`timescale 1ns/1ps

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int LG_DEPTH = 4
) (
	input logic i_clk,
	input logic i_reset,
	// Write side
	input logic i_wr,
	input logic [WIDTH-1:0] i_data,
	output logic o_full,
	// Read side
	input logic i_rd,
	output logic [WIDTH-1:0] o_data,
	output logic o_empty
);

	localparam int DEPTH = 1 << LG_DEPTH;

	// Storage
	logic [WIDTH-1:0] mem [DEPTH];

	// Pointers carry one extra wrap bit to tell full from empty
	logic [LG_DEPTH:0] wr_ptr;
	logic [LG_DEPTH:0] rd_ptr;

	logic do_wr;
	logic do_rd;

	// Equal pointers mean empty
	assign o_empty = (wr_ptr == rd_ptr);
	// Same address but other lap means full
	assign o_full = (wr_ptr[LG_DEPTH] != rd_ptr[LG_DEPTH])
		&& (wr_ptr[LG_DEPTH-1:0] == rd_ptr[LG_DEPTH-1:0]);

	// Requests that would overflow or underflow are ignored
	assign do_wr = i_wr && !o_full;
	assign do_rd = i_rd && !o_empty;

	// Write pointer
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			wr_ptr <= '0;
		else if (do_wr)
			wr_ptr <= wr_ptr + 1'b1;
	end

	// Read pointer
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			rd_ptr <= '0;
		else if (do_rd)
			rd_ptr <= rd_ptr + 1'b1;
	end

	// Data write
	always_ff @(posedge i_clk)
	begin
		if (do_wr)
			mem[wr_ptr[LG_DEPTH-1:0]] <= i_data;
	end

	// Head word shown without a read, one cycle after its write
	assign o_data = mem[rd_ptr[LG_DEPTH-1:0]];

endmodule

/* hw/w_beat_bank.sv */
// One FIFO of 2^LG_W_DEPTH beats per ID; WREADY follows the incoming id's FIFO only
`timescale 1ns/1ps

module w_beat_bank #(
	parameter int LG_W_DEPTH = 4
) (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	// Incoming, possibly interleaved, W channel
	input logic i_s_wvalid,
	output logic o_s_wready,
	input wreorder_pkg::w_beat_t i_s_wbeat,
	// Head access for the emitter
	input wreorder_pkg::axi_id_t i_sel_id,
	input logic i_pop,
	output wreorder_pkg::w_beat_t o_head,
	output logic o_head_empty
);

	import wreorder_pkg::*;

	localparam int BEAT_W = $bits(w_beat_t);

	// Per-ID strobes and flags
	logic [NUM_IDS-1:0] fifo_wr;
	logic [NUM_IDS-1:0] fifo_rd;
	logic [NUM_IDS-1:0] fifo_full;
	logic [NUM_IDS-1:0] fifo_empty;

	// Head word of every FIFO
	logic [BEAT_W-1:0] fifo_head [NUM_IDS];

	//////////////////////////////////////////////////////////////////////////////
	// Beat FIFOs
	//////////////////////////////////////////////////////////////////////////////

	for (genvar k = 0; k < NUM_IDS; k++)
	begin : g_fifo
		// Push only into the FIFO named by the beat's id
		assign fifo_wr[k] = i_s_wvalid && o_s_wready
			&& (i_s_wbeat.id == axi_id_t'(k));
		// Pop only the FIFO the emitter is draining
		assign fifo_rd[k] = i_pop && (i_sel_id == axi_id_t'(k));

		sync_fifo #(
			.WIDTH(BEAT_W),
			.LG_DEPTH(LG_W_DEPTH)
		) u_beat_fifo (
			.i_clk(S_AXI_ACLK),
			.i_reset(!S_AXI_ARESETN),
			.i_wr(fifo_wr[k]),
			.i_data(i_s_wbeat),
			.o_full(fifo_full[k]),
			.i_rd(fifo_rd[k]),
			.o_data(fifo_head[k]),
			.o_empty(fifo_empty[k])
		);
	end

	//////////////////////////////////////////////////////////////////////////////
	// Muxes
	//////////////////////////////////////////////////////////////////////////////

	// Ready follows the incoming id's FIFO
	assign o_s_wready = !fifo_full[i_s_wbeat.id];

	// Head and empty flag of the selected ID
	assign o_head = w_beat_t'(fifo_head[i_sel_id]);
	assign o_head_empty = fifo_empty[i_sel_id];

endmodule

/* hw/w_burst_emit.sv */
// Drains one ID at a time in AW order; i_m_wready reaches the bank pop combinationally
`timescale 1ns/1ps

module w_burst_emit (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	// AW ID queue head
	input wreorder_pkg::axi_id_t i_aw_id,
	input logic i_aw_empty,
	output logic o_aw_pop,
	// Beat bank access
	output wreorder_pkg::axi_id_t o_sel_id,
	output logic o_pop,
	input wreorder_pkg::w_beat_t i_head,
	input logic i_head_empty,
	// Reordered W channel
	output logic o_m_wvalid,
	input logic i_m_wready,
	output wreorder_pkg::w_beat_t o_m_wbeat
);

	import wreorder_pkg::*;

	// Burst now being sent
	axi_id_t current_id;
	logic cid_valid;

	// Output register is free or drains this cycle
	logic advance;
	// Current ID may be replaced this cycle
	logic load_slot;

	//////////////////////////////////////////////////////////////////////////////
	// Current burst ID
	//////////////////////////////////////////////////////////////////////////////

	assign advance = !o_m_wvalid || i_m_wready;

	// Idle, or the last beat of the burst leaves now
	assign load_slot = !cid_valid || (o_pop && i_head.last);

	// Take the next ID only if one is queued
	assign o_aw_pop = load_slot && !i_aw_empty;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			cid_valid <= 1'b0;
		else if (load_slot)
			cid_valid <= !i_aw_empty;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			current_id <= '0;
		else if (o_aw_pop)
			current_id <= i_aw_id;
	end

	assign o_sel_id = current_id;

	//////////////////////////////////////////////////////////////////////////////
	// Output stage
	//////////////////////////////////////////////////////////////////////////////

	// Pop when the register can take a beat and the burst has one waiting
	assign o_pop = advance && cid_valid && !i_head_empty;

	// Valid holds under back-pressure
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_m_wvalid <= 1'b0;
		else if (advance)
			o_m_wvalid <= o_pop;
	end

	// Beat loads only on a pop, so it stays stable while stalled
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_pop)
			o_m_wbeat <= i_head;
	end

endmodule

/* hw/wreorder_pkg.sv */
// ID and data widths are fixed here; changing ID_W changes the number of beat FIFOs as 2^ID_W

package wreorder_pkg;

	//////////////////////////////////////////////////////////////////////////////
	// Bus widths
	//////////////////////////////////////////////////////////////////////////////

	// Two ID bits, so four beat FIFOs
	localparam int ID_W = 2;
	localparam int DATA_W = 32;
	// One strobe bit per data byte
	localparam int STRB_W = DATA_W / 8;
	// One beat FIFO for every ID value
	localparam int NUM_IDS = 1 << ID_W;

	//////////////////////////////////////////////////////////////////////////////
	// Vector types
	//////////////////////////////////////////////////////////////////////////////

	typedef logic [ID_W-1:0] axi_id_t;
	typedef logic [DATA_W-1:0] axi_data_t;
	typedef logic [STRB_W-1:0] axi_strb_t;

	// One W beat, as carried on the input, in the FIFOs and on the output
	typedef struct packed {
		axi_id_t id;
		axi_data_t data;
		axi_strb_t strb;
		logic last;
	} w_beat_t;

endpackage

/* include/tb_wreorder_checks.svh */
// Included in the body of tb_axi3_wreorder after WAIT_LIMIT; the first failed check ends the run
`ifndef TB_WREORDER_CHECKS_SVH
`define TB_WREORDER_CHECKS_SVH

////////////////////////////////////////////////////////////////////////////
// Failure reporting
////////////////////////////////////////////////////////////////////////////

int err_count = 0;

task automatic stop_run();
	$display("Done: errors found");
	$fatal(1, "Simulation stopped at the first failure");
endtask

task automatic report_error(input string msg);
	err_count++;
	$display("error at %0t: %s", $time, msg);
	stop_run();
endtask

// Called once for every cycle a wait loop spends waiting
task automatic bump_wait(inout int waited, input string what);
	waited++;
	if (waited > WAIT_LIMIT)
	begin
		err_count++;
		$display("Gave up after %0d cycles waiting for %s", WAIT_LIMIT, what);
		stop_run();
	end
endtask

////////////////////////////////////////////////////////////////////////////
// Typed compares
////////////////////////////////////////////////////////////////////////////

task automatic check_beat(input w_beat_t act, input w_beat_t exp, input string what);
	string got;
	string want;
	got = $sformatf("id %0d data %h strb %h last %b", act.id, act.data, act.strb, act.last);
	want = $sformatf("id %0d data %h strb %h last %b", exp.id, exp.data, exp.strb, exp.last);
	if (act !== exp)
		report_error({what, ": got ", got, ", expected ", want});
endtask

task automatic check_id(input axi_id_t act, input axi_id_t exp, input string what);
	if (act !== exp)
		report_error($sformatf("%s: got id %0d, expected id %0d", what, act, exp));
endtask

task automatic check_flag(input logic act, input logic exp, input string what);
	if (act !== exp)
		report_error($sformatf("%s: got %b, expected %b", what, act, exp));
endtask

`endif

/* test/tb_axi3_wreorder.sv */
// Per-ID beat totals in a batch stay within one beat FIFO, so the random stimulus cannot deadlock
`timescale 1ns/1ps

module tb_axi3_wreorder;

	import wreorder_pkg::*;

	localparam int LG_AW_DEPTH = 3;
	localparam int LG_W_DEPTH = 4;
	localparam int W_DEPTH = 1 << LG_W_DEPTH;
	// Queue depth plus the ID held by the emitter
	localparam int AW_FILL = (1 << LG_AW_DEPTH) + 1;
	localparam int WAIT_LIMIT = 2000;
	localparam int NUM_BATCHES = 40;
	localparam int PERIOD = 100;
	// Outputs are sampled this long after the falling edge
	localparam int SETTLE = 10;

	logic S_AXI_ACLK;
	logic S_AXI_ARESETN;
	logic i_s_awvalid;
	logic o_s_awready;
	axi_id_t i_s_awid;
	logic i_s_wvalid;
	logic o_s_wready;
	w_beat_t i_s_wbeat;
	logic o_m_wvalid;
	logic i_m_wready;
	w_beat_t o_m_wbeat;

	// Model of accepted AW IDs in order and accepted beats per ID
	axi_id_t aw_model [$];
	w_beat_t beat_model [NUM_IDS][$];
	// Beats accepted but not yet sent out, per ID
	int outstanding [NUM_IDS];
	int in_count = 0;
	int out_count = 0;

	// Bursts of the current batch and their beats still to send
	axi_id_t batch_ids [$];
	w_beat_t pend [NUM_IDS][$];

	`include "tb_wreorder_checks.svh"

	axi3_wreorder #(
		.LG_AW_DEPTH(LG_AW_DEPTH),
		.LG_W_DEPTH(LG_W_DEPTH)
	) i_axi3_wreorder (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_s_awvalid(i_s_awvalid),
		.o_s_awready(o_s_awready),
		.i_s_awid(i_s_awid),
		.i_s_wvalid(i_s_wvalid),
		.o_s_wready(o_s_wready),
		.i_s_wbeat(i_s_wbeat),
		.o_m_wvalid(o_m_wvalid),
		.i_m_wready(i_m_wready),
		.o_m_wbeat(o_m_wbeat)
	);

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever
			#(PERIOD / 2) S_AXI_ACLK = ~S_AXI_ACLK;
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	function automatic w_beat_t make_beat(input axi_id_t id, input logic last);
		w_beat_t beat;
		beat.id = id;
		beat.data = axi_data_t'($urandom);
		beat.strb = axi_strb_t'($urandom);
		beat.last = last;
		return beat;
	endfunction

	task automatic send_aw(input axi_id_t id);
		int waited;
		waited = 0;
		@(negedge S_AXI_ACLK);
		i_s_awvalid <= 1'b1;
		i_s_awid <= id;
		#(SETTLE);
		while (!o_s_awready)
		begin
			bump_wait(waited, "o_s_awready");
			@(negedge S_AXI_ACLK);
			#(SETTLE);
		end
		@(posedge S_AXI_ACLK);
		aw_model.push_back(id);
	endtask

	task automatic send_w(input w_beat_t beat);
		int waited;
		waited = 0;
		@(negedge S_AXI_ACLK);
		// Random idle cycles, and never more than a FIFO of beats in flight per ID
		while (($urandom % 4 == 0) || (outstanding[beat.id] >= W_DEPTH))
		begin
			i_s_wvalid <= 1'b0;
			bump_wait(waited, "room in a beat FIFO");
			@(negedge S_AXI_ACLK);
		end
		i_s_wvalid <= 1'b1;
		i_s_wbeat <= beat;
		waited = 0;
		#(SETTLE);
		while (!o_s_wready)
		begin
			bump_wait(waited, "o_s_wready");
			@(negedge S_AXI_ACLK);
			#(SETTLE);
		end
		@(posedge S_AXI_ACLK);
		beat_model[beat.id].push_back(beat);
		outstanding[beat.id]++;
		in_count++;
	endtask

	task automatic release_inputs();
		@(negedge S_AXI_ACLK);
		i_s_awvalid <= 1'b0;
		i_s_wvalid <= 1'b0;
	endtask

	// Burst lengths for batch_ids, split so each ID's total fits one FIFO
	task automatic build_bursts();
		int uses [NUM_IDS];
		int len;
		for (int k = 0; k < NUM_IDS; k++)
			uses[k] = 0;
		foreach (batch_ids[n])
			uses[batch_ids[n]]++;
		foreach (batch_ids[n])
		begin
			len = 1 + int'($urandom % (W_DEPTH / uses[batch_ids[n]]));
			for (int b = 0; b < len; b++)
				pend[batch_ids[n]].push_back(make_beat(batch_ids[n], b == len - 1));
		end
	endtask

	task automatic send_pending();
		axi_id_t id;
		int left;
		left = 0;
		for (int k = 0; k < NUM_IDS; k++)
			left += pend[k].size();
		while (left > 0)
		begin
			// Random ID with beats left, so IDs interleave on W
			id = axi_id_t'($urandom % NUM_IDS);
			while (pend[id].size() == 0)
				id = axi_id_t'((int'(id) + 1) % NUM_IDS);
			send_w(pend[id].pop_front());
			left--;
		end
		release_inputs();
	endtask

	task automatic run_batch();
		int n;
		n = 1 + int'($urandom % 4);
		batch_ids.delete();
		repeat (n)
		begin
			batch_ids.push_back(axi_id_t'($urandom % NUM_IDS));
			send_aw(batch_ids[$]);
		end
		release_inputs();
		build_bursts();
		send_pending();
	endtask

	// With W idle, offer AW IDs until the queue refuses one
	task automatic fill_aw_queue();
		int accepted;
		int waited;
		accepted = 0;
		waited = 0;
		batch_ids.delete();
		@(negedge S_AXI_ACLK);
		i_s_awvalid <= 1'b1;
		i_s_awid <= axi_id_t'($urandom % NUM_IDS);
		#(SETTLE);
		while (o_s_awready)
		begin
			bump_wait(waited, "o_s_awready to drop");
			@(posedge S_AXI_ACLK);
			aw_model.push_back(i_s_awid);
			batch_ids.push_back(i_s_awid);
			accepted++;
			@(negedge S_AXI_ACLK);
			i_s_awid <= axi_id_t'($urandom % NUM_IDS);
			#(SETTLE);
		end
		// Refused offer is withdrawn
		@(negedge S_AXI_ACLK);
		i_s_awvalid <= 1'b0;
		check_flag(accepted == AW_FILL, 1'b1,
			$sformatf("%0d AW IDs accepted before o_s_awready dropped, expected %0d",
			accepted, AW_FILL));
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (aw_model.size() != 0)
		begin
			bump_wait(waited, "all bursts to leave");
			@(negedge S_AXI_ACLK);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Output side
	////////////////////////////////////////////////////////////////////////////

	task automatic drive_ready();
		forever
		begin
			@(negedge S_AXI_ACLK);
			// Back-pressure about one cycle in four
			i_m_wready <= ($urandom % 4 != 0);
		end
	endtask

	task automatic watch_output();
		w_beat_t held;
		w_beat_t expected;
		axi_id_t exp_id;
		axi_id_t burst_id;
		logic stalled;
		logic mid_burst;
		stalled = 1'b0;
		mid_burst = 1'b0;
		burst_id = '0;
		forever
		begin
			@(negedge S_AXI_ACLK);
			#(SETTLE);
			if (stalled)
			begin
				check_flag(o_m_wvalid, 1'b1, "o_m_wvalid dropped before its transfer");
				check_beat(o_m_wbeat, held, "o_m_wbeat changed under back-pressure");
			end
			stalled = o_m_wvalid && !i_m_wready;
			held = o_m_wbeat;
			if (o_m_wvalid && i_m_wready)
			begin
				if (mid_burst)
					check_id(o_m_wbeat.id, burst_id, "burst interrupted by another ID");
				if (aw_model.size() == 0)
					report_error("output beat with no AW ID pending in the model");
				exp_id = aw_model[0];
				if (beat_model[exp_id].size() == 0)
					report_error("output beat before its input beat was accepted");
				expected = beat_model[exp_id].pop_front();
				check_beat(o_m_wbeat, expected, "output beat");
				// Head burst retires with its last beat
				if (expected.last)
					void'(aw_model.pop_front());
				mid_burst = !o_m_wbeat.last;
				burst_id = o_m_wbeat.id;
				outstanding[exp_id]--;
				out_count++;
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		void'($urandom(32'h752c_5a56));
		S_AXI_ARESETN = 1'b0;
		i_s_awvalid = 1'b0;
		i_s_awid = '0;
		i_s_wvalid = 1'b0;
		i_s_wbeat = '0;
		i_m_wready = 1'b0;
		for (int k = 0; k < NUM_IDS; k++)
			outstanding[k] = 0;
		repeat (5) @(negedge S_AXI_ACLK);
		S_AXI_ARESETN <= 1'b1;
		#(SETTLE);
		check_flag(o_m_wvalid, 1'b0, "o_m_wvalid after reset");
		check_flag(o_s_awready, 1'b1, "o_s_awready after reset");
		check_flag(o_s_wready, 1'b1, "o_s_wready after reset");
		fork
			drive_ready();
			watch_output();
		join_none
		repeat (NUM_BATCHES) run_batch();
		wait_drain();
		// AW queue capacity and then the beats for those IDs
		fill_aw_queue();
		build_bursts();
		send_pending();
		wait_drain();
		// Nothing may follow the last expected beat
		#(SETTLE);
		check_flag(o_m_wvalid, 1'b0, "o_m_wvalid after the last burst left");
		check_flag(out_count == in_count, 1'b1,
			$sformatf("%0d beats out for %0d beats in", out_count, in_count));
		if (err_count == 0)
		begin
			$display("Done: no errors");
			$finish;
		end
		else
			stop_run();
	end

endmodule
